//--- rtl/l2_cache_pkg.sv
/*
 * L2 cache request definitions
 * Line geometry, request operation codes and queue sizing for the miss path
 */
package l2_cache_pkg;

	// Line and address geometry
	localparam int LINE_BYTES = 64;

	typedef logic [25:0] line_addr_t;
	typedef logic [5:0] set_index_t;
	typedef logic [19:0] l2_tag_t;
	typedef logic [LINE_BYTES * 8 - 1:0] line_data_t;
	typedef logic [LINE_BYTES - 1:0] byte_mask_t;

	// Request operation codes
	typedef logic [2:0] l2_op_t;

	localparam l2_op_t L2_OP_LOAD = 3'd0;
	localparam l2_op_t L2_OP_STORE = 3'd1;
	localparam l2_op_t L2_OP_LOAD_SYNC = 3'd2;
	localparam l2_op_t L2_OP_STORE_SYNC = 3'd3;
	localparam l2_op_t L2_OP_FLUSH = 3'd4;

	// Entries in each of the writeback and load queues
	localparam int REQUEST_QUEUE_LENGTH = 8;
	// Requests still in flight in the cache pipeline after a stall is raised
	localparam int REQ_LATENCY = 4;
	// Lines that can have a miss outstanding at once
	localparam int PENDING_ENTRIES = 8;

endpackage

//--- rtl/axi_bus_pkg.sv
/*
 * External bus definitions
 * Beat width, burst geometry and address and data types of the AXI-like bus
 */
package axi_bus_pkg;

	localparam int AXI_DATA_WIDTH = 32;

	typedef logic [31:0] axi_addr_t;
	typedef logic [AXI_DATA_WIDTH - 1:0] axi_data_t;
	typedef logic [7:0] axi_len_t;

	// One full line per burst
	localparam int BURST_LENGTH = 16;

	typedef logic [3:0] beat_index_t;

endpackage

//--- rtl/sync_fifo.sv
/*
 * Synchronous FIFO
 * Circular buffer with an occupancy count; shows the head entry and flags
 * empty, full and almost full
 */
module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8,
	parameter int ALMOST_FULL_THRESHOLD = 1
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               enqueue_i,
	input  logic [WIDTH - 1:0] value_i,
	input  logic               dequeue_i,
	output logic [WIDTH - 1:0] value_o,
	output logic               empty_o,
	output logic               full_o,
	output logic               almost_full_o
);
	localparam int PTR_WIDTH = $clog2(DEPTH);
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH - 1:0] storage [DEPTH];
	logic [PTR_WIDTH - 1:0] read_ptr;
	logic [PTR_WIDTH - 1:0] write_ptr;
	logic [COUNT_WIDTH - 1:0] count;
	logic do_enqueue;
	logic do_dequeue;

	// Writes to a full queue and reads from an empty one are dropped
	assign do_enqueue = enqueue_i && !full_o;
	assign do_dequeue = dequeue_i && !empty_o;

	assign value_o = storage[read_ptr];
	assign empty_o = count == '0;
	assign full_o = count == COUNT_WIDTH'(DEPTH);
	// Free entries at or below the threshold
	assign almost_full_o = (COUNT_WIDTH'(DEPTH) - count) <= COUNT_WIDTH'(ALMOST_FULL_THRESHOLD);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_enqueue)
				write_ptr <= (write_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;

			if (do_dequeue)
				read_ptr <= (read_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;

			// Simultaneous push and pop leaves the count alone
			if (do_enqueue && !do_dequeue)
				count <= count + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr] <= value_i;
	end

endmodule

//--- rtl/pending_miss_table.sv
/*
 * Pending miss table
 * Tracks line addresses with a miss outstanding and counts the queued
 * requests per line, so later misses to the same line skip the bus read
 */
module pending_miss_table (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     enqueue_load_i,
	input  l2_cache_pkg::line_addr_t enqueue_addr_i,
	output logic                     duplicate_o,
	input  logic                     reissue_valid_i,
	input  l2_cache_pkg::line_addr_t reissue_addr_i
);
	import l2_cache_pkg::*;

	localparam int INDEX_WIDTH = $clog2(PENDING_ENTRIES);

	typedef logic [3:0] ref_count_t;

	logic entry_valid [PENDING_ENTRIES];
	line_addr_t entry_addr [PENDING_ENTRIES];
	ref_count_t entry_count [PENDING_ENTRIES];
	logic [PENDING_ENTRIES - 1:0] enqueue_match;
	logic [PENDING_ENTRIES - 1:0] count_up;
	logic [PENDING_ENTRIES - 1:0] count_down;
	logic free_found;
	logic [INDEX_WIDTH - 1:0] free_index;
	logic allocate;

	always_comb
	begin
		free_found = 1'b0;
		free_index = '0;
		for (int i = 0; i < PENDING_ENTRIES; i++)
		begin
			enqueue_match[i] = entry_valid[i] && entry_addr[i] == enqueue_addr_i;
			count_down[i] = reissue_valid_i && entry_valid[i] && entry_addr[i] == reissue_addr_i;
			count_up[i] = enqueue_load_i && enqueue_match[i];

			// Lowest free slot takes a new line
			if (!entry_valid[i] && !free_found)
			begin
				free_found = 1'b1;
				free_index = INDEX_WIDTH'(i);
			end
		end
	end

	assign duplicate_o = enqueue_load_i && |enqueue_match;
	// A line with no room in the table goes to the bus untracked
	assign allocate = enqueue_load_i && !(|enqueue_match) && free_found;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < PENDING_ENTRIES; i++)
			begin
				entry_valid[i] <= 1'b0;
				entry_count[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < PENDING_ENTRIES; i++)
			begin
				if (allocate && free_index == INDEX_WIDTH'(i))
				begin
					entry_valid[i] <= 1'b1;
					entry_count[i] <= ref_count_t'(1);
				end
				else if (count_up[i] && !count_down[i])
					entry_count[i] <= entry_count[i] + 1'b1;
				else if (count_down[i] && !count_up[i])
				begin
					entry_count[i] <= entry_count[i] - 1'b1;
					// Slot is free again once its last reference is gone
					if (entry_count[i] == ref_count_t'(1))
						entry_valid[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (allocate)
			entry_addr[free_index] <= enqueue_addr_i;
	end

endmodule

//--- rtl/l2_bus_interface.sv
/*
 * L2 external bus interface
 * Queues dirty evictions and misses from the tag-read stage, moves full
 * lines over the AXI-like bus and hands finished misses back to the cache
 */
module l2_bus_interface (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     req_valid_i,
	input  l2_cache_pkg::l2_op_t     req_op_i,
	input  l2_cache_pkg::line_addr_t req_addr_i,
	input  l2_cache_pkg::byte_mask_t req_mask_i,
	input  logic                     req_is_fill_i,
	input  logic                     req_hit_i,
	input  l2_cache_pkg::line_data_t req_line_data_i,
	input  l2_cache_pkg::l2_tag_t    req_old_tag_i,
	input  logic                     req_dirty_i,
	output logic                     enqueue_load_o,
	output l2_cache_pkg::line_addr_t enqueue_addr_o,
	input  logic                     duplicate_i,
	output logic                     input_wait_o,
	output logic                     writeback_event_o,
	output logic                     reissue_valid_o,
	output logic                     reissue_duplicate_o,
	output l2_cache_pkg::l2_op_t     reissue_op_o,
	output l2_cache_pkg::line_addr_t reissue_addr_o,
	output l2_cache_pkg::byte_mask_t reissue_mask_o,
	output l2_cache_pkg::line_data_t reissue_line_o,
	output axi_bus_pkg::axi_addr_t   axi_awaddr_o,
	output axi_bus_pkg::axi_len_t    axi_awlen_o,
	output logic                     axi_awvalid_o,
	input  logic                     axi_awready_i,
	output axi_bus_pkg::axi_data_t   axi_wdata_o,
	output logic                     axi_wlast_o,
	output logic                     axi_wvalid_o,
	input  logic                     axi_wready_i,
	input  logic                     axi_bvalid_i,
	output logic                     axi_bready_o,
	output axi_bus_pkg::axi_addr_t   axi_araddr_o,
	output axi_bus_pkg::axi_len_t    axi_arlen_o,
	output logic                     axi_arvalid_o,
	input  logic                     axi_arready_i,
	input  logic                     axi_rvalid_i,
	input  axi_bus_pkg::axi_data_t   axi_rdata_i,
	output logic                     axi_rready_o
);
	import l2_cache_pkg::*;
	import axi_bus_pkg::*;

	localparam int WB_WIDTH = $bits(line_addr_t) + $bits(line_data_t);
	localparam int LOAD_WIDTH = 1 + $bits(l2_op_t) + $bits(line_addr_t) + $bits(byte_mask_t);
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);

	typedef enum logic [2:0] {
		BUS_IDLE,
		BUS_WRITE_ADDR,
		BUS_WRITE_DATA,
		BUS_READ_ADDR,
		BUS_READ_DATA,
		BUS_READ_COMPLETE
	} bus_state_t;

	set_index_t set_index;
	line_addr_t evict_addr;
	logic enqueue_writeback;
	logic enqueue_load;
	logic wb_empty;
	logic wb_full;
	logic wb_almost_full;
	logic load_empty;
	logic load_full;
	logic load_almost_full;
	line_addr_t wb_addr;
	line_data_t wb_line;
	logic writeback_done;
	logic skip_read;
	bus_state_t state;
	bus_state_t state_nxt;
	beat_index_t beat;
	beat_index_t beat_nxt;
	logic wait_write_response;
	axi_data_t load_buffer [BURST_LENGTH];

	// Evicted line address is rebuilt from the old tag and this set
	assign set_index = req_addr_i[$bits(set_index_t) - 1:0];
	assign evict_addr = {req_old_tag_i, set_index};

	assign enqueue_writeback = req_valid_i && req_dirty_i && !wb_full
		&& (req_is_fill_i || req_op_i == L2_OP_FLUSH);
	assign enqueue_load = req_valid_i && !req_hit_i && !req_is_fill_i && !load_full
		&& (req_op_i == L2_OP_LOAD || req_op_i == L2_OP_STORE
		|| req_op_i == L2_OP_LOAD_SYNC || req_op_i == L2_OP_STORE_SYNC);

	assign writeback_event_o = enqueue_writeback;
	assign enqueue_load_o = enqueue_load;
	assign enqueue_addr_o = req_addr_i;

	// Raised while the pipeline still holds REQ_LATENCY requests that may land here
	assign input_wait_o = wb_almost_full || load_almost_full;

	sync_fifo #(
		.WIDTH(WB_WIDTH),
		.DEPTH(REQUEST_QUEUE_LENGTH),
		.ALMOST_FULL_THRESHOLD(REQ_LATENCY)
	) writeback_queue (
		.clk(clk),
		.reset(reset),
		.enqueue_i(enqueue_writeback),
		.value_i({evict_addr, req_line_data_i}),
		.dequeue_i(writeback_done),
		.value_o({wb_addr, wb_line}),
		.empty_o(wb_empty),
		.full_o(wb_full),
		.almost_full_o(wb_almost_full)
	);

	sync_fifo #(
		.WIDTH(LOAD_WIDTH),
		.DEPTH(REQUEST_QUEUE_LENGTH),
		.ALMOST_FULL_THRESHOLD(REQ_LATENCY)
	) load_queue (
		.clk(clk),
		.reset(reset),
		.enqueue_i(enqueue_load),
		.value_i({duplicate_i, req_op_i, req_addr_i, req_mask_i}),
		.dequeue_i(reissue_valid_o),
		.value_o({reissue_duplicate_o, reissue_op_o, reissue_addr_o, reissue_mask_o}),
		.empty_o(load_empty),
		.full_o(load_full),
		.almost_full_o(load_almost_full)
	);

	// Another miss already brings the line in, or the store overwrites all of it
	assign skip_read = reissue_duplicate_o
		|| (reissue_op_o == L2_OP_STORE && reissue_mask_o == '1);

	assign axi_awaddr_o = {wb_addr, {OFFSET_BITS{1'b0}}};
	assign axi_araddr_o = {reissue_addr_o, {OFFSET_BITS{1'b0}}};
	assign axi_awlen_o = axi_len_t'(BURST_LENGTH - 1);
	assign axi_arlen_o = axi_len_t'(BURST_LENGTH - 1);
	assign axi_bready_o = 1'b1;

	// Beat 0 is the top word of the line
	assign axi_wdata_o = wb_line[(BURST_LENGTH - 1 - int'(beat)) * AXI_DATA_WIDTH +: AXI_DATA_WIDTH];

	always_comb
	begin
		state_nxt = state;
		beat_nxt = beat;
		writeback_done = 1'b0;
		reissue_valid_o = 1'b0;
		axi_awvalid_o = 1'b0;
		axi_wvalid_o = 1'b0;
		axi_wlast_o = 1'b0;
		axi_arvalid_o = 1'b0;
		axi_rready_o = 1'b0;

		unique case (state)
			BUS_IDLE:
			begin
				// Writebacks first so a load never reads stale memory
				if (!wb_empty)
				begin
					if (!wait_write_response)
						state_nxt = BUS_WRITE_ADDR;
				end
				else if (!load_empty)
					state_nxt = skip_read ? BUS_READ_COMPLETE : BUS_READ_ADDR;
			end

			BUS_WRITE_ADDR:
			begin
				axi_awvalid_o = 1'b1;
				beat_nxt = '0;
				if (axi_awready_i)
					state_nxt = BUS_WRITE_DATA;
			end

			BUS_WRITE_DATA:
			begin
				axi_wvalid_o = 1'b1;
				axi_wlast_o = beat == beat_index_t'(BURST_LENGTH - 1);
				if (axi_wready_i)
				begin
					beat_nxt = beat + 1'b1;
					if (axi_wlast_o)
					begin
						writeback_done = 1'b1;
						state_nxt = BUS_IDLE;
					end
				end
			end

			BUS_READ_ADDR:
			begin
				axi_arvalid_o = 1'b1;
				beat_nxt = '0;
				if (axi_arready_i)
					state_nxt = BUS_READ_DATA;
			end

			BUS_READ_DATA:
			begin
				axi_rready_o = 1'b1;
				if (axi_rvalid_i)
				begin
					beat_nxt = beat + 1'b1;
					if (beat == beat_index_t'(BURST_LENGTH - 1))
						state_nxt = BUS_READ_COMPLETE;
				end
			end

			BUS_READ_COMPLETE:
			begin
				// Hand the head request back and pop it
				reissue_valid_o = 1'b1;
				state_nxt = BUS_IDLE;
			end

			default:
				state_nxt = BUS_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= BUS_IDLE;
			beat <= '0;
			wait_write_response <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			beat <= beat_nxt;
			// Next writeback holds off until B arrives
			if (axi_awvalid_o && axi_awready_i)
				wait_write_response <= 1'b1;
			else if (axi_bvalid_i)
				wait_write_response <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == BUS_READ_DATA && axi_rvalid_i)
			load_buffer[beat] <= axi_rdata_i;
	end

	// Word k of the buffer lands k words down from the top of the line
	always_comb
	begin
		for (int k = 0; k < BURST_LENGTH; k++)
			reissue_line_o[(BURST_LENGTH - 1 - k) * AXI_DATA_WIDTH +: AXI_DATA_WIDTH] = load_buffer[k];
	end

endmodule

//--- rtl/l2_miss_unit.sv
/*
 * L2 miss unit
 * Bus interface together with the pending-miss table
 */
module l2_miss_unit (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     req_valid_i,
	input  l2_cache_pkg::l2_op_t     req_op_i,
	input  l2_cache_pkg::line_addr_t req_addr_i,
	input  l2_cache_pkg::byte_mask_t req_mask_i,
	input  logic                     req_is_fill_i,
	input  logic                     req_hit_i,
	input  l2_cache_pkg::line_data_t req_line_data_i,
	input  l2_cache_pkg::l2_tag_t    req_old_tag_i,
	input  logic                     req_dirty_i,
	output logic                     input_wait_o,
	output logic                     writeback_event_o,
	output logic                     reissue_valid_o,
	output logic                     reissue_duplicate_o,
	output l2_cache_pkg::l2_op_t     reissue_op_o,
	output l2_cache_pkg::line_addr_t reissue_addr_o,
	output l2_cache_pkg::byte_mask_t reissue_mask_o,
	output l2_cache_pkg::line_data_t reissue_line_o,
	output logic [31:0]              axi_awaddr_o,
	output logic [7:0]               axi_awlen_o,
	output logic                     axi_awvalid_o,
	input  logic                     axi_awready_i,
	output logic [31:0]              axi_wdata_o,
	output logic                     axi_wlast_o,
	output logic                     axi_wvalid_o,
	input  logic                     axi_wready_i,
	input  logic                     axi_bvalid_i,
	output logic                     axi_bready_o,
	output logic [31:0]              axi_araddr_o,
	output logic [7:0]               axi_arlen_o,
	output logic                     axi_arvalid_o,
	input  logic                     axi_arready_i,
	input  logic                     axi_rvalid_i,
	input  logic [31:0]              axi_rdata_i,
	output logic                     axi_rready_o
);
	import l2_cache_pkg::*;

	logic enqueue_load;
	line_addr_t enqueue_addr;
	logic duplicate;

	l2_bus_interface bus_interface (
		.enqueue_load_o(enqueue_load),
		.enqueue_addr_o(enqueue_addr),
		.duplicate_i(duplicate),
		.*
	);

	// Reissues release their line's reference in the table
	pending_miss_table miss_table (
		.clk(clk),
		.reset(reset),
		.enqueue_load_i(enqueue_load),
		.enqueue_addr_i(enqueue_addr),
		.duplicate_o(duplicate),
		.reissue_valid_i(reissue_valid_o),
		.reissue_addr_i(reissue_addr_o)
	);

endmodule

//--- bench/axi_mem_model.sv
/*
 * AXI memory responder for the miss unit testbench
 * Random ready and valid stalls, rule-based read data, write beat capture
 */
module axi_mem_model (
	input  logic         clk,
	input  logic         reset,
	input  logic         awvalid_i,
	output logic         awready_o,
	input  logic [31:0]  wdata_i,
	input  logic         wlast_i,
	input  logic         wvalid_i,
	output logic         wready_o,
	output logic         bvalid_o,
	input  logic         bready_i,
	input  logic [31:0]  araddr_i,
	input  logic         arvalid_i,
	output logic         arready_o,
	output logic         rvalid_o,
	output logic [31:0]  rdata_o,
	input  logic         rready_i,
	output logic [511:0] written_line_o,
	output logic [7:0]   write_count_o,
	output logic         wlast_error_o,
	output logic         order_error_o
);
	logic [31:0] seed;
	logic [3:0] w_beat;
	logic [3:0] r_beat;
	logic [25:0] r_line;
	logic r_active;
	// B still owed to the master, and AW accepted with no B yet
	logic b_owed;
	logic b_outstanding;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Ready and valid stalls change on the falling edge
	always @(negedge clk or posedge reset)
	begin
		if (reset)
		begin
			seed = 32'hfc8;
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			arready_o <= 1'b0;
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
			rdata_o <= '0;
		end
		else
		begin
			seed = next_random(seed);
			awready_o <= seed[17];
			wready_o <= seed[19] | seed[20];
			arready_o <= seed[21];
			bvalid_o <= b_owed && seed[25];
			rvalid_o <= r_active && (seed[23] | seed[24]);
			// Beat k of line A reads back as A * 16 + k
			rdata_o <= {2'b00, r_line, 4'b0000} + {28'd0, r_beat};
		end
	end

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			w_beat <= '0;
			r_beat <= '0;
			r_line <= '0;
			r_active <= 1'b0;
			b_owed <= 1'b0;
			b_outstanding <= 1'b0;
			written_line_o <= '0;
			write_count_o <= '0;
			wlast_error_o <= 1'b0;
			order_error_o <= 1'b0;
		end
		else
		begin
			if (bvalid_o && bready_i)
			begin
				b_owed <= 1'b0;
				b_outstanding <= 1'b0;
			end
			// New write address while a response is still due
			if (awvalid_i && awready_o)
			begin
				if (b_outstanding)
					order_error_o <= 1'b1;
				b_outstanding <= 1'b1;
				w_beat <= '0;
			end
			if (wvalid_i && wready_o)
			begin
				written_line_o[(4'd15 - w_beat) * 32 +: 32] <= wdata_i;
				if (wlast_i != (w_beat == 4'd15))
					wlast_error_o <= 1'b1;
				w_beat <= w_beat + 1'b1;
				if (w_beat == 4'd15)
				begin
					b_owed <= 1'b1;
					write_count_o <= write_count_o + 1'b1;
				end
			end
			if (arvalid_i && arready_o)
			begin
				r_active <= 1'b1;
				r_line <= araddr_i[31:6];
				r_beat <= '0;
			end
			if (rvalid_o && rready_i)
			begin
				r_beat <= r_beat + 1'b1;
				if (r_beat == 4'd15)
					r_active <= 1'b0;
			end
		end
	end

endmodule

//--- bench/tb_l2_miss_unit.sv
/*
 * Testbench for the L2 miss unit
 * Plays the cache pipeline, drives loads, stores, fills and flushes and
 * checks the bus traffic and reissued requests
 */
module tb_l2_miss_unit;
	import l2_cache_pkg::*;
	import axi_bus_pkg::*;

	logic clk;
	logic reset;
	logic req_valid;
	l2_op_t req_op;
	line_addr_t req_addr;
	byte_mask_t req_mask;
	logic req_is_fill;
	logic req_hit;
	line_data_t req_line;
	l2_tag_t req_old_tag;
	logic req_dirty;
	logic input_wait;
	logic writeback_event;
	logic reissue_valid;
	logic reissue_duplicate;
	l2_op_t reissue_op;
	line_addr_t reissue_addr;
	byte_mask_t reissue_mask;
	line_data_t reissue_line;
	axi_addr_t awaddr;
	axi_addr_t araddr;
	axi_len_t awlen;
	axi_len_t arlen;
	axi_data_t wdata;
	axi_data_t rdata;
	logic awvalid;
	logic awready;
	logic wlast;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic [511:0] written_line;
	logic [7:0] write_count;
	logic wlast_error;
	logic order_error;

	// Monitor captures
	int cycle;
	int reissue_count;
	int wb_events;
	int ar_count;
	int aw_cycle;
	int ar_cycle;
	l2_op_t cap_op;
	line_addr_t cap_addr;
	byte_mask_t cap_mask;
	line_data_t cap_line;
	logic cap_dup;
	axi_addr_t cap_araddr;
	axi_addr_t cap_awaddr;
	axi_len_t cap_arlen;
	axi_len_t cap_awlen;
	logic [31:0] rnd_state;

	l2_miss_unit DUT (
		.clk(clk), .reset(reset), .req_valid_i(req_valid), .req_op_i(req_op),
		.req_addr_i(req_addr), .req_mask_i(req_mask), .req_is_fill_i(req_is_fill),
		.req_hit_i(req_hit), .req_line_data_i(req_line), .req_old_tag_i(req_old_tag),
		.req_dirty_i(req_dirty), .input_wait_o(input_wait),
		.writeback_event_o(writeback_event), .reissue_valid_o(reissue_valid),
		.reissue_duplicate_o(reissue_duplicate), .reissue_op_o(reissue_op),
		.reissue_addr_o(reissue_addr), .reissue_mask_o(reissue_mask),
		.reissue_line_o(reissue_line), .axi_awaddr_o(awaddr), .axi_awlen_o(awlen),
		.axi_awvalid_o(awvalid), .axi_awready_i(awready), .axi_wdata_o(wdata),
		.axi_wlast_o(wlast), .axi_wvalid_o(wvalid), .axi_wready_i(wready),
		.axi_bvalid_i(bvalid), .axi_bready_o(bready), .axi_araddr_o(araddr),
		.axi_arlen_o(arlen), .axi_arvalid_o(arvalid), .axi_arready_i(arready),
		.axi_rvalid_i(rvalid), .axi_rdata_i(rdata), .axi_rready_o(rready)
	);

	axi_mem_model memory (
		.clk(clk), .reset(reset), .awvalid_i(awvalid),
		.awready_o(awready), .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid),
		.wready_o(wready), .bvalid_o(bvalid), .bready_i(bready), .araddr_i(araddr),
		.arvalid_i(arvalid), .arready_o(arready), .rvalid_o(rvalid), .rdata_o(rdata),
		.rready_i(rready), .written_line_o(written_line), .write_count_o(write_count),
		.wlast_error_o(wlast_error), .order_error_o(order_error)
	);

	always #10 clk = ~clk;

	// Handshakes and reissues sampled on the rising edge
	always @(posedge clk)
	begin
		if (!reset)
		begin
			cycle <= cycle + 1;
			if (writeback_event)
				wb_events <= wb_events + 1;
			if (awvalid && awready)
			begin
				cap_awaddr <= awaddr;
				cap_awlen <= awlen;
				aw_cycle <= cycle;
			end
			if (arvalid && arready)
			begin
				ar_count <= ar_count + 1;
				cap_araddr <= araddr;
				cap_arlen <= arlen;
				ar_cycle <= cycle;
			end
			if (reissue_valid)
			begin
				reissue_count <= reissue_count + 1;
				cap_op <= reissue_op;
				cap_addr <= reissue_addr;
				cap_mask <= reissue_mask;
				cap_line <= reissue_line;
				cap_dup <= reissue_duplicate;
			end
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic line_data_t random_line();
		line_data_t l;
		for (int k = 0; k < 16; k++)
		begin
			rnd_state = next_random(rnd_state);
			l[k * 32 +: 32] = rnd_state;
		end
		return l;
	endfunction

	// Word k from the top of memory line A holds A * 16 + k
	function automatic line_data_t expected_line(input line_addr_t a);
		line_data_t l;
		for (int k = 0; k < 16; k++)
			l[(15 - k) * 32 +: 32] = {2'b00, a, 4'b0000} + 32'(k);
		return l;
	endfunction

	task automatic check_value(input string name, input logic [511:0] got,
		input logic [511:0] expected);
		assert (got === expected)
		else
		begin
			$display("FAILED %s: got %0h expected %0h", name, got, expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		assert (cond === 1'b1)
		else
		begin
			$display("Check failed, %s did not hold", what);
			$display("TB FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("TB FAILED");
		$fatal(1, "timeout");
	endtask

	// Write burst protocol flags from the memory model, watched every cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			check_true("wlast only on the last beat", !wlast_error);
			check_true("no AW before the previous B", !order_error);
		end
	end

	task automatic wait_reissues(input int target);
		int i;
		i = 0;
		while (reissue_count < target && i < 4000)
		begin
			@(negedge clk);
			i++;
		end
		if (reissue_count < target)
			fail_timeout("reissue");
	endtask

	task automatic wait_writes(input int target);
		int i;
		i = 0;
		while (int'(write_count) < target && i < 4000)
		begin
			@(negedge clk);
			i++;
		end
		if (int'(write_count) < target)
			fail_timeout("write burst");
	endtask

	// One request cycle that starts and ends on a falling edge
	task automatic send_request(input l2_op_t op, input line_addr_t addr,
		input byte_mask_t mask, input logic is_fill, input logic dirty,
		input line_data_t line, input l2_tag_t old_tag);
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_mask = mask;
		req_is_fill = is_fill;
		req_dirty = dirty;
		req_line = line;
		req_old_tag = old_tag;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	initial
	begin
		int ar_before;
		int base;
		int sent;
		int after;
		logic saw_wait;
		line_data_t wb_line;
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = L2_OP_LOAD;
		req_addr = '0;
		req_mask = '0;
		req_is_fill = 1'b0;
		req_hit = 1'b0;
		req_line = '0;
		req_old_tag = '0;
		req_dirty = 1'b0;
		cycle = 0;
		reissue_count = 0;
		wb_events = 0;
		ar_count = 0;
		rnd_state = 32'hfc8;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Quiet outputs after reset
		check_value("axi awvalid wvalid arvalid rready", {awvalid, wvalid, arvalid, rready}, 0);
		check_value("reissue_valid_o", reissue_valid, 0);
		check_value("input_wait_o", input_wait, 0);
		check_value("writeback_event_o", writeback_event, 0);

		// Plain load miss
		send_request(L2_OP_LOAD, 26'h0123456, 64'hff00, 1'b0, 1'b0, '0, '0);
		wait_reissues(1);
		check_value("axi_araddr_o", cap_araddr, {26'h0123456, 6'b0});
		check_value("axi_arlen_o", cap_arlen, 8'd15);
		check_value("reissue_op_o", cap_op, L2_OP_LOAD);
		check_value("reissue_addr_o", cap_addr, 26'h0123456);
		check_value("reissue_mask_o", cap_mask, 64'hff00);
		check_value("reissue_line_o", cap_line, expected_line(26'h0123456));

		// Dirty fill evicts the old line
		wb_line = random_line();
		send_request(L2_OP_LOAD, 26'h00000a5, '0, 1'b1, 1'b1, wb_line, 20'hbeef1);
		wait_writes(1);
		check_value("writeback_event_o pulses", wb_events, 1);
		check_value("axi_awaddr_o", cap_awaddr, {20'hbeef1, 6'h25, 6'b0});
		check_value("axi_awlen_o", cap_awlen, 8'd15);
		check_value("axi_wdata_o beats", written_line, wb_line);

		// Two back-to-back flushes make the second AW wait for B
		send_request(L2_OP_FLUSH, 26'h3, '0, 1'b0, 1'b1, random_line(), 20'h11);
		wb_line = random_line();
		send_request(L2_OP_FLUSH, 26'h7, '0, 1'b0, 1'b1, wb_line, 20'h22);
		wait_writes(3);
		check_value("writeback_event_o pulses", wb_events, 3);
		check_value("axi_awaddr_o", cap_awaddr, {20'h22, 6'h07, 6'b0});
		check_value("axi_wdata_o beats", written_line, wb_line);

		// Writeback and load both queue behind a busy read and the writeback wins
		send_request(L2_OP_LOAD, 26'h1800, 64'h1, 1'b0, 1'b0, '0, '0);
		send_request(L2_OP_LOAD, 26'h10, '0, 1'b1, 1'b1, random_line(), 20'h5a5a5);
		send_request(L2_OP_LOAD, 26'h2000, 64'h1, 1'b0, 1'b0, '0, '0);
		wait_writes(4);
		wait_reissues(3);
		check_true("AW handshake before the load's AR", aw_cycle < ar_cycle);
		check_value("reissue_line_o", cap_line, expected_line(26'h2000));

		// Second miss to a pending line needs no bus read
		ar_before = ar_count;
		send_request(L2_OP_LOAD, 26'h777, 64'hf, 1'b0, 1'b0, '0, '0);
		send_request(L2_OP_LOAD_SYNC, 26'h777, 64'hf0, 1'b0, 1'b0, '0, '0);
		wait_reissues(5);
		check_value("reissue_duplicate_o", cap_dup, 1'b1);
		check_value("reissue_op_o", cap_op, L2_OP_LOAD_SYNC);
		check_value("AR count", ar_count, ar_before + 1);

		// Full-line store skips the read
		ar_before = ar_count;
		send_request(L2_OP_STORE, 26'h888, '1, 1'b0, 1'b0, '0, '0);
		wait_reissues(6);
		check_value("reissue_op_o", cap_op, L2_OP_STORE);
		check_value("reissue_addr_o", cap_addr, 26'h888);
		check_value("AR count", ar_count, ar_before);

		// Back-to-back misses until stalled and then four more at most
		base = reissue_count;
		sent = 0;
		after = 0;
		saw_wait = 1'b0;
		while (sent < 40 && after < 4)
		begin
			if (input_wait)
				saw_wait = 1'b1;
			if (saw_wait)
				after++;
			rnd_state = next_random(rnd_state);
			send_request(L2_OP_LOAD, rnd_state[31:6], 64'h3, 1'b0, 1'b0, '0, '0);
			sent++;
		end
		check_true("input_wait_o raised under back-to-back misses", saw_wait);
		wait_reissues(base + sent);
		repeat (60) @(negedge clk);
		check_value("reissue count", reissue_count, base + sent);

		$display("TB PASSED");
		$finish;
	end

endmodule

//--- flist.f
rtl/l2_cache_pkg.sv
rtl/axi_bus_pkg.sv
rtl/sync_fifo.sv
rtl/pending_miss_table.sv
rtl/l2_bus_interface.sv
rtl/l2_miss_unit.sv
bench/axi_mem_model.sv
bench/tb_l2_miss_unit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_l2_miss_unit
FILE_LIST ?= flist.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
